// ==== sqrt_defines.svh ====
/* Width and depth constants for the pipelined integer square root unit.
   Include wherever a width or the stage count is needed. */

`ifndef SQRT_DEFINES_SVH
`define SQRT_DEFINES_SVH

// Unsigned radicand width in bits
`define SQRT_RAD_W 16

// Floor root width, always half the radicand width
`define SQRT_ROOT_W 8

// Root bits decided inside one pipeline stage
// Two per clock, same as the iterative core this grew from
`define SQRT_ITERS_PER_STAGE 2

// Number of iterating stages between ingress and egress
// Root width divided by iterations per stage
`define SQRT_STAGES 4

// Width of the caller's request tag
// Tags pass through untouched so responses can be matched up
`define SQRT_TAG_W 4

`endif

// ==== sqrt_data_pkg.sv ====
/* Internal pipeline types for the square root unit.
   Shared by ingress, the iterating stages and egress. */

`include "sqrt_defines.svh"

package sqrt_data_pkg;

	// Remaining radicand needs one guard bit above the radicand
	// The subtraction never goes negative, but delta can exceed 16 bits
	localparam int EPS_W = `SQRT_RAD_W + 1;

	// Partial root width
	localparam int RES_W = `SQRT_ROOT_W;

	// State handed from one stage register to the next
	// About 30 bits in total
	typedef struct packed {
		// Slot holds a live request
		// Acts as the travelling strobe through the pipe
		logic                   valid;
		// Caller tag, carried along unchanged
		logic [`SQRT_TAG_W-1:0] tag;
		// What is left of the radicand after the bits decided so far
		logic [EPS_W-1:0]       eps;
		// Root bits decided so far, lower bits still zero
		logic [RES_W-1:0]       res;
	} stage_state_t;

	// The candidate bit is not part of the state
	// Each stage knows its own bit positions from its index

endpackage

// ==== sqrt_io_pkg.sv ====
/* Request and response types seen at the top level of the root unit.
   A producer fills sqrt_req_t, a consumer reads sqrt_rsp_t. */

`include "sqrt_defines.svh"

package sqrt_io_pkg;

	// Remainder is at most twice the root, so one bit wider than the root
	localparam int REM_W = `SQRT_ROOT_W + 1;

	// Incoming query, sampled while in_valid is high
	typedef struct packed {
		logic [`SQRT_RAD_W-1:0] radicand;
		logic [`SQRT_TAG_W-1:0] tag;
	} sqrt_req_t;

	// Outgoing answer, valid while out_valid is high
	typedef struct packed {
		// Floor of the square root
		logic [`SQRT_ROOT_W-1:0] root;
		// Radicand minus root squared
		logic [REM_W-1:0]        rem;
		// High when the radicand is a perfect square
		logic                    exact;
		// Tag of the request this answers
		logic [`SQRT_TAG_W-1:0]  tag;
	} sqrt_rsp_t;

endpackage

// ==== sqrt_ingress.sv ====
/* Entry register of the root pipeline. Captures a request and seeds
   the iteration state that stage 0 works on. */

`include "sqrt_defines.svh"

module sqrt_ingress (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        in_valid,
	input  sqrt_io_pkg::sqrt_req_t      in_req,
	output sqrt_data_pkg::stage_state_t state_out
);

	// Local copy of the eps width for the zero extension below
	localparam int EPS_W = sqrt_data_pkg::EPS_W;

	// Seed state built from the raw request
	sqrt_data_pkg::stage_state_t seed;

	always_comb begin
		seed.valid = in_valid;
		seed.tag   = in_req.tag;
		// Whole radicand is still left to take apart
		seed.eps   = EPS_W'(in_req.radicand);
		// No root bits decided yet
		seed.res   = '0;
	end

	// A new state is loaded on every clock
	// Idle cycles simply load a slot with valid low
	always_ff @(posedge clk) begin
		state_out.tag <= seed.tag;
		state_out.eps <= seed.eps;
		state_out.res <= seed.res;
		// Only the strobe is cleared on reset
		if (rst) begin
			state_out.valid <= 1'b0;
		end else begin
			state_out.valid <= seed.valid;
		end
	end

endmodule

// ==== sqrt_stage.sv ====
/* One root pipeline stage. Decides two root bits with the restoring
   digit-by-digit rule and registers the updated state. */

`include "sqrt_defines.svh"

module sqrt_stage #(
	// Stage index, 0 decides the top root bits
	parameter int STAGE = 0
) (
	input  logic                        clk,
	input  logic                        rst,
	input  sqrt_data_pkg::stage_state_t state_in,
	output sqrt_data_pkg::stage_state_t state_out
);

	localparam int EPS_W = sqrt_data_pkg::EPS_W;
	localparam int RES_W = sqrt_data_pkg::RES_W;
	localparam int ITERS = `SQRT_ITERS_PER_STAGE;

	// Highest root bit this stage decides
	// Stage 0 takes bits 7 and 6, stage 3 takes bits 1 and 0
	localparam int TOP_BIT = `SQRT_ROOT_W - 1 - STAGE * ITERS;

	// Intermediate values between the chained iterations
	// Index 0 is the stage input, index ITERS the stage result
	logic [EPS_W-1:0] eps_step [ITERS+1];
	logic [RES_W-1:0] res_step [ITERS+1];

	assign eps_step[0] = state_in.eps;
	assign res_step[0] = state_in.res;

	// Iterations run one after the other within the same cycle
	for (genvar i = 0; i < ITERS; i++) begin : g_iter
		// Candidate bit position, fixed at elaboration
		localparam int K = TOP_BIT - i;

		// Cost of setting bit K on top of the partial root
		// (res + 2^K)^2 - res^2 = res * 2^(K+1) + 2^(2K)
		logic [EPS_W-1:0] delta;
		// Candidate bit fits under what is left of the radicand
		logic             take;

		assign delta = (EPS_W'(res_step[i]) << (K + 1)) + (EPS_W'(1) << (2 * K));
		assign take  = (delta <= eps_step[i]);

		// Keep the bit and pay for it, or leave both alone
		assign eps_step[i+1] = take ? (eps_step[i] - delta) : eps_step[i];
		assign res_step[i+1] = take ? (res_step[i] | (RES_W'(1) << K)) : res_step[i];
	end

	// Stage register
	always_ff @(posedge clk) begin
		state_out.tag <= state_in.tag;
		state_out.eps <= eps_step[ITERS];
		state_out.res <= res_step[ITERS];
		// Data moves regardless, the strobe decides if it counts
		if (rst) begin
			state_out.valid <= 1'b0;
		end else begin
			state_out.valid <= state_in.valid;
		end
	end

endmodule

// ==== sqrt_egress.sv ====
/* Exit register of the root pipeline. Turns the final iteration state
   into a response with remainder and exact flag. */

module sqrt_egress (
	input  logic                        clk,
	input  logic                        rst,
	input  sqrt_data_pkg::stage_state_t state_in,
	output logic                        out_valid,
	output sqrt_io_pkg::sqrt_rsp_t      out_rsp
);

	localparam int REM_W = sqrt_io_pkg::REM_W;

	// Response assembled from the last stage's state
	sqrt_io_pkg::sqrt_rsp_t rsp;

	always_comb begin
		// All root bits are decided by now
		rsp.root  = state_in.res;
		// Leftover radicand is the remainder
		// Never more than 2 * root, so the upper eps bits are always zero
		rsp.rem   = state_in.eps[REM_W-1:0];
		// Perfect square when nothing is left over
		rsp.exact = (rsp.rem == '0);
		rsp.tag   = state_in.tag;
	end

	// Response register, payload is loaded every cycle
	always_ff @(posedge clk) begin
		out_rsp <= rsp;
	end

	// Output strobe follows the travelling valid bit
	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= state_in.valid;
		end
	end

endmodule

// ==== isqrt_pipeline.sv ====
/* Pipelined integer square root, one request per cycle, fixed latency of six.
   Chains ingress, the iterating stages and egress. */

`include "sqrt_defines.svh"

module isqrt_pipeline (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   in_valid,
	input  sqrt_io_pkg::sqrt_req_t in_req,
	output logic                   out_valid,
	output sqrt_io_pkg::sqrt_rsp_t out_rsp
);

	// State between registers
	// Entry 0 leaves ingress, entry SQRT_STAGES feeds egress
	sqrt_data_pkg::stage_state_t state [`SQRT_STAGES+1];

	// Request capture and seeding
	sqrt_ingress u_ingress (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_req    (in_req),
		.state_out (state[0])
	);

	// Iterating stages, top root bits first
	for (genvar s = 0; s < `SQRT_STAGES; s++) begin : g_stage
		sqrt_stage #(
			.STAGE (s)
		) u_stage (
			.clk       (clk),
			.rst       (rst),
			.state_in  (state[s]),
			.state_out (state[s+1])
		);
	end

	// Response formatting
	sqrt_egress u_egress (
		.clk       (clk),
		.rst       (rst),
		.state_in  (state[`SQRT_STAGES]),
		.out_valid (out_valid),
		.out_rsp   (out_rsp)
	);

endmodule

// ==== tb_isqrt_pipeline.sv ====
/* Testbench for the pipelined square root unit. Applies pattern-file and random
   requests, checks every response, its latency and behavior around reset. */

`include "sqrt_defines.svh"

module tb_isqrt_pipeline;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_PAT        = 36;
	localparam int N_RAND       = 200;
	localparam int N_RESET_REQS = 4;
	localparam int LATENCY      = 6;
	// Pattern run, isolated request, random run, lost and recovered reset requests
	localparam int TOTAL_REQS   = N_PAT + 1 + N_RAND + 2 * N_RESET_REQS;
	localparam int TIMEOUT      = 4 * TOTAL_REQS + 100;

	// One expected response, queued when its request is driven
	typedef struct packed {
		logic [`SQRT_ROOT_W-1:0]        root;
		logic [sqrt_io_pkg::REM_W-1:0] rem;
		logic                          exact;
		logic [`SQRT_TAG_W-1:0]         tag;
		// Cycle count seen by the monitor when out_valid should be high
		logic [31:0]                   due;
	} expect_t;

	logic                   clk;
	logic                   rst;
	logic                   in_valid;
	sqrt_io_pkg::sqrt_req_t in_req;
	logic                   out_valid;
	sqrt_io_pkg::sqrt_rsp_t out_rsp;

	// Radicand, root and remainder words, three per case
	logic [15:0]            pat_mem [0:3*N_PAT-1];
	expect_t                exp_q [$];
	logic [`SQRT_TAG_W-1:0] next_tag = '0;
	int                     cycle_count = 0;
	int                     value_errors = 0;
	int                     other_errors = 0;
	int                     resp_count = 0;
	int                     seed = 14;

	isqrt_pipeline u_dut (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_req    (in_req),
		.out_valid (out_valid),
		.out_rsp   (out_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	// Largest root whose square does not exceed x
	function automatic logic [7:0] floor_sqrt(input logic [15:0] x);
		int r;
		r = 0;
		while ((r + 1) * (r + 1) <= int'(x)) begin
			r++;
		end
		return 8'(r);
	endfunction

	// Drive one request on the next rising edge and queue its expectation
	task automatic send_request(input logic [15:0] radicand, input logic [7:0] root,
			input logic [8:0] rem);
		expect_t want;
		@(posedge clk);
		in_valid        <= 1'b1;
		in_req.radicand <= radicand;
		in_req.tag      <= next_tag;
		want.root  = root;
		want.rem   = rem;
		want.exact = (int'(root) * int'(root) == int'(radicand));
		want.tag   = next_tag;
		// Count read here still lags this edge by one
		// The strobe is sampled next edge, out_valid rises six edges after this one
		want.due   = 32'(cycle_count + LATENCY + 1);
		exp_q.push_back(want);
		next_tag = next_tag + `SQRT_TAG_W'(1);
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
	endtask

	// Drop in-flight requests with a three cycle reset
	task automatic pulse_reset();
		@(posedge clk);
		in_valid <= 1'b0;
		rst      <= 1'b1;
		exp_q.delete();
		repeat (3) @(posedge clk);
		rst <= 1'b0;
	endtask

	// Response checker, samples between rising edges
	always @(negedge clk) begin
		expect_t want;
		if (out_valid) begin
			resp_count++;
			if (exp_q.size() == 0) begin
				$display("Unexpected out_valid at %0t with no request outstanding", $time);
				other_errors++;
			end else begin
				want = exp_q.pop_front();
				if (out_rsp.tag != want.tag) begin
					$display("FAIL %0t: tag %0d, expected %0d", $time, out_rsp.tag, want.tag);
					value_errors++;
				end
				if (out_rsp.root != want.root) begin
					$display("FAIL %0t: tag %0d root %0d, expected %0d", $time, want.tag,
						out_rsp.root, want.root);
					value_errors++;
				end
				if (out_rsp.rem != want.rem) begin
					$display("FAIL %0t: tag %0d remainder %0d, expected %0d", $time, want.tag,
						out_rsp.rem, want.rem);
					value_errors++;
				end
				if (out_rsp.exact != want.exact) begin
					$display("FAIL %0t: tag %0d exact %0b, expected %0b", $time, want.tag,
						out_rsp.exact, want.exact);
					value_errors++;
				end
				if (cycle_count != int'(want.due)) begin
					$display("Response for tag %0d came at cycle %0d instead of cycle %0d",
						want.tag, cycle_count, want.due);
					other_errors++;
				end
			end
		end
	end

	// Hang guard
	initial begin
		while (cycle_count < TIMEOUT) begin
			@(posedge clk);
		end
		$display("Timeout after %0d cycles with %0d responses still outstanding",
			cycle_count, exp_q.size());
		$display("Test failed");
		$finish;
	end

	initial begin
		int          gap;
		logic [15:0] rad;
		logic [7:0]  root;
		rst      = 1'b1;
		in_valid = 1'b0;
		in_req   = '0;
		$readmemh("sqrt_patterns.mem", pat_mem);
		repeat (3) @(posedge clk);
		rst <= 1'b0;

		// Pattern cases back to back
		for (int i = 0; i < N_PAT; i++) begin
			send_request(pat_mem[3*i], pat_mem[3*i+1][7:0], pat_mem[3*i+2][8:0]);
		end
		idle_cycle();
		wait_drain();

		// A lone request, any extra strobe is flagged by the checker
		send_request(16'd200, 8'd14, 9'd4);
		idle_cycle();
		wait_drain();

		// Random radicands with random gaps of 0 to 2 idle cycles
		for (int n = 0; n < N_RAND; n++) begin
			gap = int'($unsigned($random(seed)) % 3);
			repeat (gap) idle_cycle();
			rad  = 16'($random(seed));
			root = floor_sqrt(rad);
			send_request(rad, root, 9'(int'(rad) - int'(root) * int'(root)));
		end
		idle_cycle();
		wait_drain();

		// Requests in flight at reset must never come out
		for (int n = 0; n < N_RESET_REQS; n++) begin
			send_request(16'(1000 + n), floor_sqrt(16'(1000 + n)), 9'(39 + n));
		end
		pulse_reset();
		repeat (10) @(posedge clk);
		for (int n = 0; n < N_RESET_REQS; n++) begin
			send_request(16'(4096 + n), 8'd64, 9'(n));
		end
		idle_cycle();
		wait_drain();
		repeat (2) @(posedge clk);

		if (resp_count != TOTAL_REQS - N_RESET_REQS) begin
			$display("Saw %0d responses but %0d requests should have completed",
				resp_count, TOTAL_REQS - N_RESET_REQS);
			other_errors++;
		end
		$display("Errors: %0d wrong values, %0d timing or protocol, %0d responses seen",
			value_errors, other_errors, resp_count);
		if (value_errors + other_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== sqrt_patterns.mem ====
// Columns: radicand (16 bit), expected floor root (8 bit), expected remainder (9 bit)
// All values hex, one case per line
0000 00 000
0001 01 000
0002 01 001
0003 01 002
0004 02 000
0005 02 001
0008 02 004
0009 03 000
000f 03 006
0010 04 000
0018 04 008
0019 05 000
0063 09 012
0064 0a 000
00ff 0f 01e
0100 10 000
0101 10 001
03e8 1f 027
0400 20 000
0fff 3f 07e
1000 40 000
2710 64 000
3039 6f 018
3fff 7f 0fe
4000 80 000
7530 ad 047
7fff b5 006
8000 b5 007
9c40 c8 000
c350 df 10f
ea60 f4 1d0
fe00 fe 1fc
fe01 ff 000
ffff ff 1fe
ff00 ff 0ff
aaaa d1 009

// ==== compile.f ====
+incdir+.
sqrt_data_pkg.sv
sqrt_io_pkg.sv
sqrt_ingress.sv
sqrt_stage.sv
sqrt_egress.sv
isqrt_pipeline.sv
tb_isqrt_pipeline.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the square root pipeline testbench with Verilator and runs it.
# Exit status is 0 only when the log holds the pass message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_isqrt

verilator --binary --timing -f compile.f --top-module tb_isqrt_pipeline -o "$BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$LOG"
	echo "Simulation exited with an error"
	exit 1
fi

cat "$LOG"

grep -q "Test completed successfully" "$LOG"
if [ $? -ne 0 ]; then
	echo "Pass message not found in $LOG"
	exit 1
fi

exit 0
